//--- src/cache_be_pkg.sv
/* Cache back end shared definitions. Default bus widths, helpers that derive
   strobe and address field sizes, and the state types of both channel FSMs */

`default_nettype none

package cache_be_pkg;

   localparam int DEF_ADDR_W        = 32; // Byte address on both sides
   localparam int DEF_DATA_W        = 32;
   localparam int DEF_WORD_OFFSET_W = 2;  // Four words per line

   // Number of byte strobes in one word
   function automatic int strb_w(input int data_w);
      return data_w / 8;
   endfunction

   // Width of the byte select inside a word
   function automatic int byte_offset_w(input int data_w);
      return $clog2(data_w / 8);
   endfunction

   // Width of a word address
   function automatic int word_addr_w(input int addr_w, input int data_w);
      return addr_w - byte_offset_w(data_w);
   endfunction

   // Width of a line address
   function automatic int line_addr_w(input int addr_w, input int data_w,
                                      input int word_offset_w);
      return addr_w - byte_offset_w(data_w) - word_offset_w;
   endfunction

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_REQ,  // Word request on the bus
      RD_WAIT  // Waiting for read data
   } rd_state_t;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_REQ,  // Strobed write on the bus
      WR_ACK   // Waiting for the write acknowledge
   } wr_state_t;

endpackage

`default_nettype wire

//--- src/cache_read_channel.sv
/* Cache line fill engine. Requests every word of the replaced line in order
   and forwards each returned word to the cache with its index */

`default_nettype none

module cache_read_channel #(
   parameter int ADDR_W        = cache_be_pkg::DEF_ADDR_W,
   parameter int DATA_W        = cache_be_pkg::DEF_DATA_W,
   parameter int WORD_OFFSET_W = cache_be_pkg::DEF_WORD_OFFSET_W
) (
   input  wire                      clk_i,
   input  wire                      reset_i,

   // Cache side
   input  wire                      replace_valid_i,
   input  wire [cache_be_pkg::line_addr_w(ADDR_W, DATA_W, WORD_OFFSET_W)-1:0]
                                    replace_addr_i,
   input  wire                      write_busy_i,
   output logic                     replace_o,
   output logic                     read_valid_o,
   output logic [WORD_OFFSET_W-1:0] read_addr_o,
   output logic [DATA_W-1:0]        read_rdata_o,

   // Memory side
   output logic [ADDR_W-1:0]        be_addr_o,
   output logic                     be_valid_o,
   input  wire                      be_ready_i,
   input  wire                      be_ack_i,
   input  wire  [DATA_W-1:0]        be_rdata_i
);

   import cache_be_pkg::*;

   localparam int BYTE_OFF_W = byte_offset_w(DATA_W);
   localparam int LINE_W     = line_addr_w(ADDR_W, DATA_W, WORD_OFFSET_W);
   localparam logic [WORD_OFFSET_W-1:0] LAST_WORD = '1;

   rd_state_t                state;
   logic [LINE_W-1:0]        line_addr;
   logic [WORD_OFFSET_W-1:0] word_cnt;
   logic                     fill_start;
   logic                     word_done;

   // A fill may not overtake a store that is still in flight
   assign fill_start = (state == RD_IDLE) && replace_valid_i && !write_busy_i;
   assign word_done  = (state == RD_WAIT) && be_ack_i;

   assign be_valid_o = (state == RD_REQ);
   assign be_addr_o  = {line_addr, word_cnt, {BYTE_OFF_W{1'b0}}}; // Word aligned

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state        <= RD_IDLE;
         word_cnt     <= '0;
         replace_o    <= 1'b0;
         read_valid_o <= 1'b0;
      end else begin
         read_valid_o <= 1'b0; // One pulse per returned word
         case (state)
            RD_IDLE: begin
               if (fill_start) begin
                  state     <= RD_REQ;
                  word_cnt  <= '0;
                  replace_o <= 1'b1;
               end
            end
            RD_REQ: begin
               if (be_ready_i) begin // Held here while the bus stalls
                  state <= RD_WAIT;
               end
            end
            RD_WAIT: begin
               if (be_ack_i) begin
                  read_valid_o <= 1'b1;
                  if (word_cnt == LAST_WORD) begin
                     state     <= RD_IDLE;
                     replace_o <= 1'b0;
                  end else begin
                     state    <= RD_REQ;
                     word_cnt <= word_cnt + 1'b1;
                  end
               end
            end
            default: begin
               state <= RD_IDLE;
            end
         endcase
      end
   end

   // Line address and returned words
   always_ff @(posedge clk_i) begin
      if (fill_start) begin
         line_addr <= replace_addr_i;
      end
      if (word_done) begin
         read_addr_o  <= word_cnt;
         read_rdata_o <= be_rdata_i;
      end
   end

endmodule

`default_nettype wire

//--- src/cache_write_channel.sv
/* One-entry write-through buffer. Holds a single store, issues it as a
   strobed bus write and frees the entry once the write is acknowledged */

`default_nettype none

module cache_write_channel #(
   parameter int ADDR_W = cache_be_pkg::DEF_ADDR_W,
   parameter int DATA_W = cache_be_pkg::DEF_DATA_W
) (
   input  wire                                     clk_i,
   input  wire                                     reset_i,

   // Cache side
   input  wire                                     valid_i,
   input  wire [cache_be_pkg::word_addr_w(ADDR_W, DATA_W)-1:0]
                                                   addr_i,
   input  wire [cache_be_pkg::strb_w(DATA_W)-1:0]  wstrb_i,
   input  wire [DATA_W-1:0]                        wdata_i,
   output logic                                    ready_o,
   output logic                                    busy_o,

   // Memory side
   output logic [ADDR_W-1:0]                       be_addr_o,
   output logic                                    be_valid_o,
   output logic [DATA_W-1:0]                       be_wdata_o,
   output logic [cache_be_pkg::strb_w(DATA_W)-1:0] be_wstrb_o,
   input  wire                                     be_ready_i,
   input  wire                                     be_ack_i
);

   import cache_be_pkg::*;

   localparam int STRB_W     = strb_w(DATA_W);
   localparam int BYTE_OFF_W = byte_offset_w(DATA_W);
   localparam int WORD_W     = word_addr_w(ADDR_W, DATA_W);

   wr_state_t         state;
   logic [WORD_W-1:0] addr_q;
   logic [STRB_W-1:0] wstrb_q;
   logic [DATA_W-1:0] wdata_q;
   logic              store_in;

   assign ready_o  = (state == WR_IDLE);
   assign busy_o   = (state != WR_IDLE); // Keeps fills behind a pending store
   assign store_in = valid_i && ready_o;

   assign be_valid_o = (state == WR_REQ);
   assign be_addr_o  = {addr_q, {BYTE_OFF_W{1'b0}}};
   assign be_wdata_o = wdata_q;
   assign be_wstrb_o = be_valid_o ? wstrb_q : '0; // Zero strobe outside a write

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state <= WR_IDLE;
      end else begin
         case (state)
            WR_IDLE: begin
               if (store_in) begin
                  state <= WR_REQ;
               end
            end
            WR_REQ: begin
               if (be_ready_i) begin
                  state <= WR_ACK;
               end
            end
            WR_ACK: begin
               if (be_ack_i) begin
                  state <= WR_IDLE;
               end
            end
            default: begin
               state <= WR_IDLE;
            end
         endcase
      end
   end

   // The held store stays stable until the entry is freed
   always_ff @(posedge clk_i) begin
      if (store_in) begin
         addr_q  <= addr_i;
         wstrb_q <= wstrb_i;
         wdata_q <= wdata_i;
      end
   end

endmodule

`default_nettype wire

//--- src/cache_back_end.sv
/* Data cache back end. Merges the line fill and write-through channels onto
   one word-wide memory bus and generates the registered write acknowledge */

`default_nettype none

module cache_back_end #(
   parameter int ADDR_W        = cache_be_pkg::DEF_ADDR_W,
   parameter int DATA_W        = cache_be_pkg::DEF_DATA_W,
   parameter int WORD_OFFSET_W = cache_be_pkg::DEF_WORD_OFFSET_W
) (
   input  wire                                     clk_i,
   input  wire                                     reset_i,

   // Line fill
   input  wire                                     replace_valid_i,
   input  wire [cache_be_pkg::line_addr_w(ADDR_W, DATA_W, WORD_OFFSET_W)-1:0]
                                                   replace_addr_i,
   output logic                                    replace_o,
   output logic                                    read_valid_o,
   output logic [WORD_OFFSET_W-1:0]                read_addr_o,
   output logic [DATA_W-1:0]                       read_rdata_o,

   // Store
   input  wire                                     write_valid_i,
   input  wire [cache_be_pkg::word_addr_w(ADDR_W, DATA_W)-1:0]
                                                   write_addr_i,
   input  wire [cache_be_pkg::strb_w(DATA_W)-1:0]  write_wstrb_i,
   input  wire [DATA_W-1:0]                        write_wdata_i,
   output logic                                    write_ready_o,

   // Memory bus
   output logic                                    iob_valid_o,
   output logic [ADDR_W-1:0]                       iob_addr_o,
   output logic [DATA_W-1:0]                       iob_wdata_o,
   output logic [cache_be_pkg::strb_w(DATA_W)-1:0] iob_wstrb_o,
   input  wire                                     iob_ready_i,
   input  wire                                     iob_rvalid_i,
   input  wire  [DATA_W-1:0]                       iob_rdata_i
);

   import cache_be_pkg::*;

   localparam int STRB_W = strb_w(DATA_W);

   logic [ADDR_W-1:0] be_addr_read;
   logic [ADDR_W-1:0] be_addr_write;
   logic              be_valid_read;
   logic              be_valid_write;
   logic [DATA_W-1:0] be_wdata_write;
   logic [STRB_W-1:0] be_wstrb_write;
   logic              be_ready_write;
   logic              write_grant;
   logic              write_busy;
   logic              be_wack;
   logic              be_wack_r;
   logic              be_ack;

   // A store still waiting for the bus must not cut into a running fill
   assign write_grant    = ~replace_o;
   assign be_ready_write = iob_ready_i & write_grant;

   assign iob_valid_o = be_valid_read | (be_valid_write & write_grant);
   assign iob_addr_o  = be_valid_read ? be_addr_read : be_addr_write;
   assign iob_wdata_o = be_wdata_write;
   assign iob_wstrb_o = be_valid_read ? '0 : be_wstrb_write; // Reads carry no strobe

   assign be_wack = iob_valid_o & iob_ready_i & (|iob_wstrb_o);
   assign be_ack  = iob_rvalid_i | be_wack_r;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         be_wack_r <= 1'b0;
      end else begin
         be_wack_r <= be_wack; // Writes are acknowledged on the following cycle
      end
   end

   cache_read_channel #(
      .ADDR_W       (ADDR_W),
      .DATA_W       (DATA_W),
      .WORD_OFFSET_W(WORD_OFFSET_W)
   ) read_fsm (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .replace_valid_i(replace_valid_i),
      .replace_addr_i (replace_addr_i),
      .write_busy_i   (write_busy),
      .replace_o      (replace_o),
      .read_valid_o   (read_valid_o),
      .read_addr_o    (read_addr_o),
      .read_rdata_o   (read_rdata_o),
      .be_addr_o      (be_addr_read),
      .be_valid_o     (be_valid_read),
      .be_ready_i     (iob_ready_i),
      .be_ack_i       (be_ack),
      .be_rdata_i     (iob_rdata_i)
   );

   cache_write_channel #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) write_fsm (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .valid_i   (write_valid_i),
      .addr_i    (write_addr_i),
      .wstrb_i   (write_wstrb_i),
      .wdata_i   (write_wdata_i),
      .ready_o   (write_ready_o),
      .busy_o    (write_busy),
      .be_addr_o (be_addr_write),
      .be_valid_o(be_valid_write),
      .be_wdata_o(be_wdata_write),
      .be_wstrb_o(be_wstrb_write),
      .be_ready_i(be_ready_write),
      .be_ack_i  (be_ack)
   );

endmodule

`default_nettype wire

//--- test/mem_model.sv
/* Behavioral word memory for the cache back end bus. Applies byte strobes on
   writes, returns read data one cycle after acceptance and stalls on request */

`default_nettype none

module mem_model #(
   parameter int ADDR_W  = cache_be_pkg::DEF_ADDR_W,
   parameter int DATA_W  = cache_be_pkg::DEF_DATA_W,
   parameter int DEPTH_W = 6
) (
   input  wire                                    clk_i,
   input  wire                                    reset_i,
   input  wire                                    stall_i,
   input  wire                                    valid_i,
   input  wire [ADDR_W-1:0]                       addr_i,
   input  wire [DATA_W-1:0]                       wdata_i,
   input  wire [cache_be_pkg::strb_w(DATA_W)-1:0] wstrb_i,
   output logic                                   ready_o,
   output logic                                   rvalid_o,
   output logic [DATA_W-1:0]                      rdata_o
);

   import cache_be_pkg::*;

   localparam int STRB_W     = strb_w(DATA_W);
   localparam int BYTE_OFF_W = byte_offset_w(DATA_W);

   logic [DATA_W-1:0]  mem [0:2**DEPTH_W-1];
   logic [DEPTH_W-1:0] index;
   logic               accept;

   // Every index bit takes part in the start pattern
   function automatic logic [DATA_W-1:0] init_word(input int word);
      return {~word[15:0], word[15:0] ^ 16'h3c5a};
   endfunction

   initial begin
      for (int i = 0; i < 2**DEPTH_W; i++) begin
         mem[i] = init_word(i);
      end
   end

   assign ready_o = !stall_i;
   assign accept  = valid_i && ready_o;
   assign index   = addr_i[BYTE_OFF_W +: DEPTH_W];

   always @(posedge clk_i) begin
      if (reset_i) begin
         rvalid_o <= 1'b0;
      end else begin
         rvalid_o <= accept && (wstrb_i == '0); // Only reads return data
      end
      if (accept && (wstrb_i == '0)) begin
         rdata_o <= mem[index];
      end
      if (accept) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (wstrb_i[b]) begin
               mem[index][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- test/tb_cache_back_end.sv
/* Testbench for the cache back end. Runs directed fills and stores against a
   behavioral memory with random bus stalls and a shadow memory image */

`default_nettype none

module tb_cache_back_end;

   import cache_be_pkg::*;

   localparam int ADDR_W        = DEF_ADDR_W;
   localparam int DATA_W        = DEF_DATA_W;
   localparam int WORD_OFFSET_W = DEF_WORD_OFFSET_W;
   localparam int STRB_W        = strb_w(DATA_W);
   localparam int LINE_W        = line_addr_w(ADDR_W, DATA_W, WORD_OFFSET_W);
   localparam int WORD_W        = word_addr_w(ADDR_W, DATA_W);
   localparam int WORDS         = 2 ** WORD_OFFSET_W;
   localparam int DEPTH_W       = 6;
   localparam int MAX_STALL     = 3;  // Longest run of stalled cycles
   localparam int NUM_TESTS     = 14; // Fills and stores together
   localparam int CYCLE_LIMIT   = NUM_TESTS * WORDS * 2 * MAX_STALL + 300;
   localparam logic [31:0] SEED = 32'hb4c4;

   logic                     clk_i;
   logic                     reset_i;
   logic                     replace_valid_i;
   logic [LINE_W-1:0]        replace_addr_i;
   logic                     replace_o;
   logic                     read_valid_o;
   logic [WORD_OFFSET_W-1:0] read_addr_o;
   logic [DATA_W-1:0]        read_rdata_o;
   logic                     write_valid_i;
   logic [WORD_W-1:0]        write_addr_i;
   logic [STRB_W-1:0]        write_wstrb_i;
   logic [DATA_W-1:0]        write_wdata_i;
   logic                     write_ready_o;
   logic                     iob_valid_o;
   logic [ADDR_W-1:0]        iob_addr_o;
   logic [DATA_W-1:0]        iob_wdata_o;
   logic [STRB_W-1:0]        iob_wstrb_o;
   logic                     iob_ready_i;
   logic                     iob_rvalid_i;
   logic [DATA_W-1:0]        iob_rdata_i;

   logic              stall;
   logic              stall_en;
   int                stall_run;
   logic [31:0]       stall_lfsr;
   logic [31:0]       data_lfsr;
   int                cycles;
   logic [DATA_W-1:0] shadow [0:2**DEPTH_W-1];
   logic              prev_stalled;
   logic [ADDR_W-1:0] prev_addr;
   logic [DATA_W-1:0] prev_wdata;
   logic [STRB_W-1:0] prev_wstrb;

   cache_back_end #(
      .ADDR_W       (ADDR_W),
      .DATA_W       (DATA_W),
      .WORD_OFFSET_W(WORD_OFFSET_W)
   ) UUT (.*);

   mem_model #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W),
      .DEPTH_W(DEPTH_W)
   ) mem (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .stall_i (stall),
      .valid_i (iob_valid_o),
      .addr_i  (iob_addr_o),
      .wdata_i (iob_wdata_o),
      .wstrb_i (iob_wstrb_o),
      .ready_o (iob_ready_i),
      .rvalid_o(iob_rvalid_i),
      .rdata_o (iob_rdata_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
   endfunction

   function automatic logic [DATA_W-1:0] init_word(input int word);
      return {~word[15:0], word[15:0] ^ 16'h3c5a};
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_word,
                                                     input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] result;
      result = old_word;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            result[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return result;
   endfunction

   task automatic draw_random(input int n, output logic [31:0] value);
      value = '0;
      for (int k = 0; k < n; k++) begin
         data_lfsr = lfsr_next(data_lfsr);
         value     = {value[30:0], data_lfsr[0]};
      end
   endtask

   task automatic report_error(input string msg);
      $display("[ERROR] %0t: %s", $time, msg);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic check_word(input string what, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         report_error($sformatf("%s: expected %h, got %h", what, exp, got));
      end
   endtask

   task automatic check_index(input string what, input logic [WORD_OFFSET_W-1:0] got,
                              input logic [WORD_OFFSET_W-1:0] exp);
      if (got !== exp) begin
         report_error($sformatf("%s: expected %0d, got %0d", what, exp, got));
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         report_error($sformatf("%s: expected %b, got %b", what, exp, got));
      end
   endtask

   // One LFSR bit per cycle sets the stall and runs are capped at MAX_STALL
   always @(posedge clk_i) begin
      stall_lfsr = lfsr_next(stall_lfsr);
      if (stall_en && stall_lfsr[0] && (stall_run < MAX_STALL)) begin
         stall     <= 1'b1;
         stall_run <= stall_run + 1;
      end else begin
         stall     <= 1'b0;
         stall_run <= 0;
      end
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Done: errors found");
         $fatal(1);
      end
   end

   // A stalled request must hold still until the memory takes it
   always @(posedge clk_i) begin
      if (!reset_i && prev_stalled) begin
         check_bit("valid held under stall", iob_valid_o, 1'b1);
         check_bit("address held under stall", iob_addr_o == prev_addr, 1'b1);
         check_bit("strobe held under stall", iob_wstrb_o == prev_wstrb, 1'b1);
         if (prev_wstrb != '0) begin
            check_word("write data held under stall", iob_wdata_o, prev_wdata);
         end
      end
      prev_stalled <= iob_valid_o && !iob_ready_i;
      prev_addr    <= iob_addr_o;
      prev_wdata   <= iob_wdata_o;
      prev_wstrb   <= iob_wstrb_o;
   end

   task automatic check_reset_state;
      check_bit("iob_valid_o after reset", iob_valid_o, 1'b0);
      check_bit("replace_o after reset", replace_o, 1'b0);
      check_bit("read_valid_o after reset", read_valid_o, 1'b0);
      check_bit("write_ready_o after reset", write_ready_o, 1'b1);
   endtask

   task automatic fill_line(input int line);
      int count;
      int base;
      count = 0;
      base  = line * WORDS;
      @(posedge clk_i);
      replace_valid_i <= 1'b1;
      replace_addr_i  <= LINE_W'(line);
      @(posedge clk_i);
      while (!replace_o) begin
         @(posedge clk_i);
      end
      replace_valid_i <= 1'b0;
      check_bit("no store pending at fill start", write_ready_o, 1'b1);
      while (replace_o) begin
         @(posedge clk_i);
         if (read_valid_o) begin
            check_index("fill word index", read_addr_o, count[WORD_OFFSET_W-1:0]);
            check_word("fill data", read_rdata_o, shadow[base + count]);
            count++;
         end
      end
      check_bit("one word per line entry", count == WORDS, 1'b1);
      check_bit("replace_o falls with the last word", read_valid_o, 1'b1);
   endtask

   // Returns once the store is taken and the shadow already holds it
   task automatic start_store(input int word, input logic [STRB_W-1:0] strb,
                              input logic [DATA_W-1:0] data);
      @(posedge clk_i);
      write_valid_i <= 1'b1;
      write_addr_i  <= WORD_W'(word);
      write_wstrb_i <= strb;
      write_wdata_i <= data;
      @(posedge clk_i);
      while (!write_ready_o) begin
         @(posedge clk_i);
      end
      write_valid_i <= 1'b0;
      shadow[word] = merge_bytes(shadow[word], data, strb);
   endtask

   task automatic finish_store;
      @(posedge clk_i);
      while (!write_ready_o) begin
         @(posedge clk_i);
      end
   endtask

   task automatic random_line_test(input int line);
      logic [31:0] pick;
      logic [31:0] strb;
      logic [31:0] data;
      draw_random(WORD_OFFSET_W, pick);
      draw_random(STRB_W, strb);
      draw_random(DATA_W, data);
      if (strb[STRB_W-1:0] == '0) begin
         strb = 32'h1;
      end
      start_store(line * WORDS + int'(pick), strb[STRB_W-1:0], data[DATA_W-1:0]);
      finish_store();
      fill_line(line);
   endtask

   initial begin
      stall_lfsr      = SEED;
      data_lfsr       = SEED;
      stall           = 1'b0;
      stall_en        = 1'b0;
      stall_run       = 0;
      cycles          = 0;
      prev_stalled    = 1'b0;
      reset_i         = 1'b1;
      replace_valid_i = 1'b0;
      replace_addr_i  = '0;
      write_valid_i   = 1'b0;
      write_addr_i    = '0;
      write_wstrb_i   = '0;
      write_wdata_i   = '0;
      for (int i = 0; i < 2**DEPTH_W; i++) begin
         shadow[i] = init_word(i);
      end
      repeat (16) @(posedge clk_i);
      reset_i <= 1'b0;
      @(posedge clk_i);
      check_reset_state();
      fill_line(0);
      fill_line(1);
      start_store(2 * WORDS + 1, 4'b0101, 32'hdead_beef); // Partial strobe
      finish_store();
      fill_line(2);
      stall_en <= 1'b1;
      for (int line = 4; line < 8; line++) begin
         random_line_test(line);
      end
      start_store(9 * WORDS + 3, 4'b1100, 32'h1234_5678); // Fill queued behind it
      fill_line(9);
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- cache_back_end.f
src/cache_be_pkg.sv
src/cache_read_channel.sv
src/cache_write_channel.sv
src/cache_back_end.sv
test/mem_model.sv
test/tb_cache_back_end.sv

//--- Bender.yml
package:
  name: cache_back_end

sources:
  - files:
      - src/cache_be_pkg.sv
      - src/cache_read_channel.sv
      - src/cache_write_channel.sv
      - src/cache_back_end.sv
  - target: test
    files:
      - test/mem_model.sv
      - test/tb_cache_back_end.sv
